//--- Makefile
TOP := decode_stage_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- bench/decode_stage_tb.sv
/* decode stage testbench */
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_stage_tb;

  typedef struct packed {
    decode_pkg::id_ex_t     ie;
    decode_pkg::redirect_t  rd;
    decode_pkg::bht_upd_t   bu;
    logic [`REG_ADDR_W-1:0] ra1;
    logic [`REG_ADDR_W-1:0] ra2;
  } expect_t;

  localparam int DRAIN_LIMIT = 20;

  logic                   clk;
  logic                   rst_i;
  logic                   inst_valid_i;
  logic [`INST_W-1:0]     inst_i;
  logic [`XLEN-1:0]       pc_i;
  logic                   phb_i;
  logic [`REG_ADDR_W-1:0] rf_raddr1_o;
  logic [`REG_ADDR_W-1:0] rf_raddr2_o;
  logic [`XLEN-1:0]       rf_rdata1_i;
  logic [`XLEN-1:0]       rf_rdata2_i;
  decode_pkg::fwd_src_t   alu1_i;
  decode_pkg::fwd_src_t   alu2_i;
  decode_pkg::fwd_src_t   mem_i;
  decode_pkg::id_ex_t     id_ex_o;
  decode_pkg::redirect_t  redirect_o;
  decode_pkg::bht_upd_t   bht_upd_o;

  expect_t     exp_q[$];
  int unsigned errors;
  int unsigned checks;

  tb_clock #(.PERIOD_NS(10)) u_clock (.clk_o(clk));

  decode_stage i_decode_stage (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .phb_i        (phb_i),
    .rf_raddr1_o  (rf_raddr1_o),
    .rf_raddr2_o  (rf_raddr2_o),
    .rf_rdata1_i  (rf_rdata1_i),
    .rf_rdata2_i  (rf_rdata2_i),
    .alu1_i       (alu1_i),
    .alu2_i       (alu2_i),
    .mem_i        (mem_i),
    .id_ex_o      (id_ex_o),
    .redirect_o   (redirect_o),
    .bht_upd_o    (bht_upd_o)
  );

  // regfile contents, x0 reads zero
  function automatic logic [`XLEN-1:0] rf_pattern(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0) return '0;
    return 64'h9e37_79b9_7f4a_7c15 * (addr + 1) ^ {59'h0, addr};
  endfunction

  assign rf_rdata1_i = rf_pattern(rf_raddr1_o);
  assign rf_rdata2_i = rf_pattern(rf_raddr2_o);

  function automatic logic [`XLEN-1:0] pick_operand(input logic [4:0] addr,
      input decode_pkg::fwd_src_t a1, input decode_pkg::fwd_src_t a2,
      input decode_pkg::fwd_src_t m);
    logic h1;
    logic h2;
    h1 = a1.rd_ena && a1.rd_addr == addr;
    h2 = a2.rd_ena && a2.rd_addr == addr;
    if (h1 && h2) return (a1.pc > a2.pc) ? a1.data : a2.data;
    if (h1) return a1.data;
    if (h2) return a2.data;
    if (m.rd_ena && m.rd_addr == addr) return m.data;
    return rf_pattern(addr);
  endfunction

  function automatic expect_t ref_model(input logic rst, input logic valid,
      input logic [31:0] inst, input logic [63:0] pc, input logic phb,
      input decode_pkg::fwd_src_t a1, input decode_pkg::fwd_src_t a2,
      input decode_pkg::fwd_src_t m);
    expect_t     e;
    logic [4:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        r1;
    logic        r2;
    logic        tk;
    logic        live;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] sum;
    e = '0;
    opc = inst[6:2];
    f3 = inst[14:12];
    f7 = inst[31:25];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h0};
    e.ie.op = decode_pkg::op_none;
    case (opc)
      `OPC_LOAD: begin
        e.ie.cls = decode_pkg::cls_load;
        e.ie.op = decode_pkg::op_load;
      end
      `OPC_STORE: begin
        e.ie.cls = decode_pkg::cls_store;
        e.ie.op = decode_pkg::op_store;
      end
      `OPC_JAL: begin
        e.ie.cls = decode_pkg::cls_jal;
        e.ie.op = decode_pkg::op_jal;
      end
      `OPC_JALR: begin
        e.ie.cls = decode_pkg::cls_jalr;
        e.ie.op = decode_pkg::op_jalr;
      end
      `OPC_LUI: begin
        e.ie.cls = decode_pkg::cls_lui;
        e.ie.op = decode_pkg::op_lui;
      end
      `OPC_AUIPC: begin
        e.ie.cls = decode_pkg::cls_auipc;
        e.ie.op = decode_pkg::op_auipc;
      end
      `OPC_BRANCH: begin
        e.ie.cls = decode_pkg::cls_branch;
        case (f3)
          3'd0: e.ie.op = decode_pkg::op_beq;
          3'd1: e.ie.op = decode_pkg::op_bne;
          3'd4: e.ie.op = decode_pkg::op_blt;
          3'd5: e.ie.op = decode_pkg::op_bge;
          3'd6: e.ie.op = decode_pkg::op_bltu;
          3'd7: e.ie.op = decode_pkg::op_bgeu;
          default: e.ie.op = decode_pkg::op_none;
        endcase
      end
      `OPC_OP, `OPC_OP_IMM: begin
        e.ie.cls = (opc == `OPC_OP) ? decode_pkg::cls_reg_reg : decode_pkg::cls_reg_imm;
        if (opc == `OPC_OP && f7[0]) begin
          e.ie.op = decode_pkg::alu_op_e'(decode_pkg::op_mul + f3);
        end else begin
          case (f3)
            3'd0: e.ie.op = (opc == `OPC_OP && f7[5]) ? decode_pkg::op_sub : decode_pkg::op_add;
            3'd1: e.ie.op = decode_pkg::op_sll;
            3'd2: e.ie.op = decode_pkg::op_slt;
            3'd3: e.ie.op = decode_pkg::op_sltu;
            3'd4: e.ie.op = decode_pkg::op_xor;
            3'd5: e.ie.op = inst[30] ? decode_pkg::op_sra : decode_pkg::op_srl;
            3'd6: e.ie.op = decode_pkg::op_or;
            3'd7: e.ie.op = decode_pkg::op_and;
          endcase
        end
      end
      `OPC_OP_32, `OPC_OP_IMM_32: begin
        e.ie.cls = (opc == `OPC_OP_32) ? decode_pkg::cls_reg_reg_w : decode_pkg::cls_reg_imm_w;
        if (opc == `OPC_OP_32 && f7[0]) begin
          case (f3)
            3'd0: e.ie.op = decode_pkg::op_mulw;
            3'd4: e.ie.op = decode_pkg::op_divw;
            3'd5: e.ie.op = decode_pkg::op_divuw;
            3'd6: e.ie.op = decode_pkg::op_remw;
            3'd7: e.ie.op = decode_pkg::op_remuw;
            default: e.ie.op = decode_pkg::op_none;
          endcase
        end else begin
          case (f3)
            3'd0: e.ie.op = (opc == `OPC_OP_32 && f7[5]) ? decode_pkg::op_subw
                                                         : decode_pkg::op_addw;
            3'd1: e.ie.op = decode_pkg::op_sllw;
            3'd5: e.ie.op = inst[30] ? decode_pkg::op_sraw : decode_pkg::op_srlw;
            default: e.ie.op = decode_pkg::op_none;
          endcase
        end
      end
      default: e.ie.cls = decode_pkg::cls_none;
    endcase
    r1 = !(e.ie.cls inside {decode_pkg::cls_none, decode_pkg::cls_jal,
                            decode_pkg::cls_lui, decode_pkg::cls_auipc});
    r2 = e.ie.cls inside {decode_pkg::cls_store, decode_pkg::cls_branch,
                          decode_pkg::cls_reg_reg, decode_pkg::cls_reg_reg_w};
    e.ra1 = r1 ? inst[19:15] : 5'd0;
    e.ra2 = r2 ? inst[24:20] : 5'd0;
    if (r1) e.ie.op1 = pick_operand(inst[19:15], a1, a2, m);
    else if (e.ie.cls inside {decode_pkg::cls_auipc, decode_pkg::cls_jal}) e.ie.op1 = pc;
    if (r2) e.ie.op2 = pick_operand(inst[24:20], a1, a2, m);
    else if (e.ie.cls inside {decode_pkg::cls_reg_imm, decode_pkg::cls_reg_imm_w,
                              decode_pkg::cls_jalr}) e.ie.op2 = imm_i;
    else if (e.ie.cls inside {decode_pkg::cls_lui, decode_pkg::cls_auipc}) e.ie.op2 = imm_u;
    else if (e.ie.cls == decode_pkg::cls_jal) e.ie.op2 = pc;
    if (e.ie.cls == decode_pkg::cls_load) e.ie.mem_addr = e.ie.op1 + imm_i;
    if (e.ie.cls == decode_pkg::cls_store) e.ie.mem_addr = e.ie.op1 + imm_s;
    e.ie.rd_ena = inst[11:7] != 0 && !(e.ie.cls inside {decode_pkg::cls_none,
                  decode_pkg::cls_store, decode_pkg::cls_branch});
    e.ie.rd_addr = inst[11:7];
    e.ie.pc = pc;
    e.ie.funct3 = f3;
    live = valid && !rst;
    e.ie.valid = live;
    case (f3)
      3'd0: tk = e.ie.op1 == e.ie.op2;
      3'd1: tk = e.ie.op1 != e.ie.op2;
      3'd4: tk = $signed(e.ie.op1) < $signed(e.ie.op2);
      3'd5: tk = $signed(e.ie.op1) >= $signed(e.ie.op2);
      3'd6: tk = e.ie.op1 < e.ie.op2;
      default: tk = e.ie.op1 >= e.ie.op2;
    endcase
    if (e.ie.cls == decode_pkg::cls_branch) begin
      e.bu = '{ena: live, index: pc[5:2], taken: tk};
      e.rd.ena = live && tk != phb;
      e.rd.pc = phb ? pc + 64'd4 : pc + imm_b;
    end else if (e.ie.cls == decode_pkg::cls_jalr) begin
      sum = e.ie.op1 + imm_i;
      e.rd.ena = live;
      e.rd.pc = {sum[63:1], 1'b0};
    end
    return e;
  endfunction

  task automatic report(input string name, input logic [63:0] e, input logic [63:0] g);
    checks++;
    if (e !== g) begin
      errors++;
      $display("MISMATCH %s expected %h got %h", name, e, g);
    end
  endtask

  task automatic check_id_ex(input decode_pkg::id_ex_t e, input decode_pkg::id_ex_t g);
    report("id_ex_o.valid", 64'(e.valid), 64'(g.valid));
    if (e.valid) begin
      report("id_ex_o.cls", 64'(e.cls), 64'(g.cls));
      report("id_ex_o.op", 64'(e.op), 64'(g.op));
      report("id_ex_o.op1", e.op1, g.op1);
      report("id_ex_o.op2", e.op2, g.op2);
      report("id_ex_o.rd_ena", 64'(e.rd_ena), 64'(g.rd_ena));
      report("id_ex_o.rd_addr", 64'(e.rd_addr), 64'(g.rd_addr));
      report("id_ex_o.pc", e.pc, g.pc);
      report("id_ex_o.mem_addr", e.mem_addr, g.mem_addr);
      report("id_ex_o.funct3", 64'(e.funct3), 64'(g.funct3));
    end
  endtask

  task automatic check_redirect(input decode_pkg::redirect_t e, input decode_pkg::redirect_t g);
    report("redirect_o.ena", 64'(e.ena), 64'(g.ena));
    if (e.ena) report("redirect_o.pc", e.pc, g.pc);
  endtask

  task automatic check_bht(input decode_pkg::bht_upd_t e, input decode_pkg::bht_upd_t g);
    report("bht_upd_o.ena", 64'(e.ena), 64'(g.ena));
    if (e.ena) begin
      report("bht_upd_o.index", 64'(e.index), 64'(g.index));
      report("bht_upd_o.taken", 64'(e.taken), 64'(g.taken));
    end
  endtask

  // back entry matches the inputs now applied, front entry the registered outputs
  always @(negedge clk) begin
    expect_t e;
    if (exp_q.size() > 0) begin
      report("rf_raddr1_o", 64'(exp_q[$].ra1), 64'(rf_raddr1_o));
      report("rf_raddr2_o", 64'(exp_q[$].ra2), 64'(rf_raddr2_o));
    end
    if (exp_q.size() >= 2) begin
      e = exp_q.pop_front();
      check_id_ex(e.ie, id_ex_o);
      check_redirect(e.rd, redirect_o);
      check_bht(e.bu, bht_upd_o);
    end
  end

  task automatic drive(input logic rst, input logic valid, input logic [31:0] inst,
      input logic [63:0] pc, input logic phb, input decode_pkg::fwd_src_t a1,
      input decode_pkg::fwd_src_t a2, input decode_pkg::fwd_src_t m);
    @(posedge clk);
    rst_i        <= rst;
    inst_valid_i <= valid;
    inst_i       <= inst;
    pc_i         <= pc;
    phb_i        <= phb;
    alu1_i       <= a1;
    alu2_i       <= a2;
    mem_i        <= m;
    exp_q.push_back(ref_model(rst, valid, inst, pc, phb, a1, a2, m));
  endtask

  function automatic decode_pkg::fwd_src_t rand_src(input int unsigned addr_range);
    decode_pkg::fwd_src_t s;
    s.rd_ena  = $urandom % 4 != 0;
    s.rd_addr = 5'($urandom % addr_range);
    s.pc      = {32'h0, $urandom};
    s.data    = {$urandom, $urandom};
    return s;
  endfunction

  function automatic logic [31:0] rand_inst(input logic [4:0] opc, input int unsigned rs_range);
    logic [31:0] w;
    w = $urandom;
    w[6:0] = {opc, 2'b11};
    w[19:15] = 5'($urandom % rs_range);
    w[24:20] = 5'($urandom % rs_range);
    return w;
  endfunction

  initial begin
    logic [4:0]  alu_opc[4];
    logic [4:0]  misc_opc[6];
    logic [6:0]  f7_opts[3];
    logic [2:0]  br_f3[6];
    logic [31:0] w;
    int          waited;
    void'($urandom(32'hfef0_8c32));
    alu_opc  = '{`OPC_OP, `OPC_OP_IMM, `OPC_OP_32, `OPC_OP_IMM_32};
    misc_opc = '{`OPC_JAL, `OPC_JALR, `OPC_LUI, `OPC_AUIPC, `OPC_LOAD, `OPC_STORE};
    f7_opts  = '{7'h00, 7'h20, 7'h01};
    br_f3    = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    errors = 0;
    checks = 0;
    rst_i = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    phb_i = 1'b0;
    alu1_i = '0;
    alu2_i = '0;
    mem_i = '0;
    // jalr and branch under reset would raise redirect and bht enables
    repeat (2) drive(1'b1, 1'b1, rand_inst(`OPC_JALR, 32), 64'h100, 1'b0, '0, '0, '0);
    repeat (2) drive(1'b1, 1'b1, rand_inst(`OPC_BRANCH, 32), 64'h100, 1'b0, '0, '0, '0);
    // idle cycles
    repeat (4) drive(1'b0, 1'b0, rand_inst(`OPC_BRANCH, 32), 64'h200, 1'b1, '0, '0, '0);
    // alu decode, no producers
    repeat (80) begin
      w = rand_inst(alu_opc[$urandom % 4], 32);
      if (w[5]) w[31:25] = f7_opts[$urandom % 3];
      drive(1'b0, 1'b1, w, {32'h0, $urandom}, 1'b0, '0, '0, '0);
    end
    // forwarding with overlapping addresses
    repeat (120) begin
      w = rand_inst(alu_opc[$urandom % 2], 4);
      w[31:25] = 7'h00;
      drive(1'b0, 1'b1, w, {32'h0, $urandom}, 1'b0, rand_src(4), rand_src(4), rand_src(4));
    end
    // branches, both predictions
    for (int i = 0; i < 6; i++) begin
      for (int p = 0; p < 2; p++) begin
        repeat (8) begin
          w = rand_inst(`OPC_BRANCH, 3);
          w[14:12] = br_f3[i];
          drive(1'b0, 1'b1, w, {32'h0, $urandom}, p[0], rand_src(3), rand_src(3), '0);
        end
      end
    end
    // jumps, upper immediates, memory
    repeat (60) begin
      drive(1'b0, 1'b1, rand_inst(misc_opc[$urandom % 6], 4), {32'h0, $urandom}, 1'b0,
            rand_src(4), rand_src(4), rand_src(4));
    end
    repeat (2) drive(1'b0, 1'b0, '0, '0, 1'b0, '0, '0, '0);
    waited = 0;
    while (exp_q.size() > 1 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() > 1) begin
      $display("timeout while waiting for the last records to be compared");
      $display("Checks failed");
    end else begin
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/* testbench clock */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 10
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- hdl/branch_resolve.sv
/* branch and jump resolution */
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module branch_resolve (
  input  decode_pkg::decoded_t  dec_i,
  input  logic [`XLEN-1:0]      pc_i,
  input  logic [`XLEN-1:0]      op1_i,
  input  logic [`XLEN-1:0]      op2_i,
  input  logic                  phb_i,
  output decode_pkg::redirect_t redirect_o,
  output decode_pkg::bht_upd_t  bht_upd_o
);

  logic             is_branch;
  logic             is_jalr;
  logic             taken;
  logic             mispredict;
  logic [`XLEN-1:0] branch_tgt;
  logic [`XLEN-1:0] jalr_sum;

  assign is_branch = dec_i.cls == decode_pkg::cls_branch;
  assign is_jalr   = dec_i.cls == decode_pkg::cls_jalr;

  always_comb begin
    taken = 1'b0;
    if (is_branch) begin
      case (dec_i.funct3)
        3'b000:  taken = op1_i == op2_i;
        3'b001:  taken = op1_i != op2_i;
        3'b100:  taken = $signed(op1_i) < $signed(op2_i);
        3'b101:  taken = $signed(op1_i) >= $signed(op2_i);
        3'b110:  taken = op1_i < op2_i;
        3'b111:  taken = op1_i >= op2_i;
        default: taken = 1'b0;
      endcase
    end
  end

  assign mispredict = is_branch && (taken != phb_i);

  // recover to the path that was not predicted
  assign branch_tgt = phb_i ? pc_i + `XLEN'd4
                            : pc_i + {{(`XLEN-13){dec_i.imm_b[12]}}, dec_i.imm_b};
  assign jalr_sum   = op1_i + {{(`XLEN-12){dec_i.imm_i[11]}}, dec_i.imm_i};

  always_comb begin
    redirect_o.ena = mispredict || is_jalr;
    if (mispredict) begin
      redirect_o.pc = branch_tgt;
    end else if (is_jalr) begin
      redirect_o.pc = {jalr_sum[`XLEN-1:1], 1'b0};
    end else begin
      redirect_o.pc = '0;
    end
  end

  assign bht_upd_o.ena   = is_branch;
  assign bht_upd_o.index = pc_i[`BHT_INDEX_W+1:2];
  assign bht_upd_o.taken = taken;

endmodule

`default_nettype wire

//--- hdl/decode_config.svh
/* decode stage widths and opcodes */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath widths
`define XLEN         64
`define REG_ADDR_W   5
`define INST_W       32

// history table indexed by pc[5:2]
`define BHT_INDEX_W  4

// major opcodes, inst[6:2]
`define OPC_LOAD       5'b00000
`define OPC_STORE      5'b01000
`define OPC_BRANCH     5'b11000
`define OPC_JAL        5'b11011
`define OPC_JALR       5'b11001
`define OPC_LUI        5'b01101
`define OPC_AUIPC      5'b00101
`define OPC_OP         5'b01100
`define OPC_OP_IMM     5'b00100
`define OPC_OP_32      5'b01110
`define OPC_OP_IMM_32  5'b00110

`endif

//--- hdl/decode_pkg.sv
/* decode stage types */
`default_nettype none

`include "decode_config.svh"

package decode_pkg;

  typedef enum logic [3:0] {
    cls_none, cls_load, cls_store, cls_branch,
    cls_reg_reg, cls_reg_imm, cls_reg_reg_w, cls_reg_imm_w,
    cls_jal, cls_jalr, cls_lui, cls_auipc
  } inst_class_e;

  // immediate forms share the register opcode, class tells them apart
  typedef enum logic [5:0] {
    op_none, op_add, op_sub, op_sll, op_slt, op_sltu,
    op_xor, op_srl, op_sra, op_or, op_and,
    op_addw, op_subw, op_sllw, op_srlw, op_sraw,
    op_mul, op_mulh, op_mulhsu, op_mulhu,
    op_div, op_divu, op_rem, op_remu,
    op_mulw, op_divw, op_divuw, op_remw, op_remuw,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lui, op_auipc, op_jal, op_jalr, op_load, op_store
  } alu_op_e;

  typedef struct packed {
    logic                   rd_ena;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       data;
  } fwd_src_t;

  typedef struct packed {
    logic                   valid;
    inst_class_e            cls;
    alu_op_e                op;
    logic [`XLEN-1:0]       op1;
    logic [`XLEN-1:0]       op2;
    logic                   rd_ena;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       mem_addr;
    logic [2:0]             funct3;
  } id_ex_t;

  typedef struct packed {
    logic             ena;
    logic [`XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic                    ena;
    logic [`BHT_INDEX_W-1:0] index;
    logic                    taken;
  } bht_upd_t;

  // raw immediates, consumers sign-extend
  typedef struct packed {
    inst_class_e            cls;
    alu_op_e                op;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_ena;
    logic                   read1;
    logic                   read2;
    logic [11:0]            imm_i;
    logic [11:0]            imm_s;
    logic [12:0]            imm_b;
    logic [19:0]            imm_u;
    logic [2:0]             funct3;
  } decoded_t;

endpackage

`default_nettype wire

//--- hdl/decode_stage.sv
/* decode stage top */
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   inst_valid_i,
  input  logic [`INST_W-1:0]     inst_i,
  input  logic [`XLEN-1:0]       pc_i,
  input  logic                   phb_i,
  output logic [`REG_ADDR_W-1:0] rf_raddr1_o,
  output logic [`REG_ADDR_W-1:0] rf_raddr2_o,
  input  logic [`XLEN-1:0]       rf_rdata1_i,
  input  logic [`XLEN-1:0]       rf_rdata2_i,
  input  decode_pkg::fwd_src_t   alu1_i,
  input  decode_pkg::fwd_src_t   alu2_i,
  input  decode_pkg::fwd_src_t   mem_i,
  output decode_pkg::id_ex_t     id_ex_o,
  output decode_pkg::redirect_t  redirect_o,
  output decode_pkg::bht_upd_t   bht_upd_o
);

  decode_pkg::decoded_t  dec;
  decode_pkg::id_ex_t    id_ex_d;
  decode_pkg::redirect_t redirect_d;
  decode_pkg::bht_upd_t  bht_upd_d;
  logic [`XLEN-1:0]      fwd_data1;
  logic [`XLEN-1:0]      fwd_data2;
  logic [`XLEN-1:0]      op1;
  logic [`XLEN-1:0]      op2;
  logic [`XLEN-1:0]      imm_i_sext;
  logic [`XLEN-1:0]      imm_s_sext;

  inst_decoder u_decoder (
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  assign rf_raddr1_o = dec.read1 ? dec.rs1 : '0;
  assign rf_raddr2_o = dec.read2 ? dec.rs2 : '0;

  operand_forward u_fwd_op1 (
    .read_i    (dec.read1),
    .addr_i    (dec.rs1),
    .rf_data_i (rf_rdata1_i),
    .alu1_i    (alu1_i),
    .alu2_i    (alu2_i),
    .mem_i     (mem_i),
    .data_o    (fwd_data1),
    .fwd_o     ()
  );

  operand_forward u_fwd_op2 (
    .read_i    (dec.read2),
    .addr_i    (dec.rs2),
    .rf_data_i (rf_rdata2_i),
    .alu1_i    (alu1_i),
    .alu2_i    (alu2_i),
    .mem_i     (mem_i),
    .data_o    (fwd_data2),
    .fwd_o     ()
  );

  assign imm_i_sext = {{(`XLEN-12){dec.imm_i[11]}}, dec.imm_i};
  assign imm_s_sext = {{(`XLEN-12){dec.imm_s[11]}}, dec.imm_s};

  // operand sources when a register is not read
  always_comb begin
    if (dec.read1) begin
      op1 = fwd_data1;
    end else if (dec.cls inside {decode_pkg::cls_auipc, decode_pkg::cls_jal}) begin
      op1 = pc_i;
    end else begin
      op1 = '0;
    end

    if (dec.read2) begin
      op2 = fwd_data2;
    end else if (dec.cls inside {decode_pkg::cls_reg_imm, decode_pkg::cls_reg_imm_w,
                                 decode_pkg::cls_jalr}) begin
      op2 = imm_i_sext;
    end else if (dec.cls inside {decode_pkg::cls_lui, decode_pkg::cls_auipc}) begin
      op2 = {{(`XLEN-32){dec.imm_u[19]}}, dec.imm_u, 12'b0};
    end else if (dec.cls == decode_pkg::cls_jal) begin
      op2 = pc_i;
    end else begin
      op2 = '0;
    end
  end

  branch_resolve u_branch (
    .dec_i      (dec),
    .pc_i       (pc_i),
    .op1_i      (op1),
    .op2_i      (op2),
    .phb_i      (phb_i),
    .redirect_o (redirect_d),
    .bht_upd_o  (bht_upd_d)
  );

  always_comb begin
    id_ex_d.valid   = inst_valid_i;
    id_ex_d.cls     = dec.cls;
    id_ex_d.op      = dec.op;
    id_ex_d.op1     = op1;
    id_ex_d.op2     = op2;
    id_ex_d.rd_ena  = dec.rd_ena;
    id_ex_d.rd_addr = dec.rd;
    id_ex_d.pc      = pc_i;
    id_ex_d.funct3  = dec.funct3;
    case (dec.cls)
      decode_pkg::cls_load:  id_ex_d.mem_addr = op1 + imm_i_sext;
      decode_pkg::cls_store: id_ex_d.mem_addr = op1 + imm_s_sext;
      default:               id_ex_d.mem_addr = '0;
    endcase
  end

  // one-cycle output register, only the qualifiers see reset
  always_ff @(posedge clk) begin
    id_ex_o        <= id_ex_d;
    redirect_o     <= redirect_d;
    bht_upd_o      <= bht_upd_d;
    redirect_o.ena <= inst_valid_i && redirect_d.ena;
    bht_upd_o.ena  <= inst_valid_i && bht_upd_d.ena;
    if (rst_i) begin
      id_ex_o.valid  <= 1'b0;
      redirect_o.ena <= 1'b0;
      bht_upd_o.ena  <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/inst_decoder.sv
/* instruction decoder */
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module inst_decoder (
  input  logic [`INST_W-1:0]  inst_i,
  output decode_pkg::decoded_t dec_o
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst_i[6:2];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    dec_o        = '0;
    dec_o.rs1    = inst_i[19:15];
    dec_o.rs2    = inst_i[24:20];
    dec_o.rd     = inst_i[11:7];
    dec_o.funct3 = funct3;
    dec_o.imm_i  = inst_i[31:20];
    dec_o.imm_s  = {inst_i[31:25], inst_i[11:7]};
    dec_o.imm_b  = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    dec_o.imm_u  = inst_i[31:12];
    dec_o.cls    = decode_pkg::cls_none;
    dec_o.op     = decode_pkg::op_none;

    case (opcode)
      `OPC_LOAD: begin
        dec_o.cls = decode_pkg::cls_load;
        dec_o.op  = decode_pkg::op_load;
      end
      `OPC_STORE: begin
        dec_o.cls = decode_pkg::cls_store;
        dec_o.op  = decode_pkg::op_store;
      end
      `OPC_BRANCH: begin
        dec_o.cls = decode_pkg::cls_branch;
        case (funct3)
          3'b000:  dec_o.op = decode_pkg::op_beq;
          3'b001:  dec_o.op = decode_pkg::op_bne;
          3'b100:  dec_o.op = decode_pkg::op_blt;
          3'b101:  dec_o.op = decode_pkg::op_bge;
          3'b110:  dec_o.op = decode_pkg::op_bltu;
          3'b111:  dec_o.op = decode_pkg::op_bgeu;
          default: dec_o.op = decode_pkg::op_none;
        endcase
      end
      `OPC_JAL: begin
        dec_o.cls = decode_pkg::cls_jal;
        dec_o.op  = decode_pkg::op_jal;
      end
      `OPC_JALR: begin
        dec_o.cls = decode_pkg::cls_jalr;
        dec_o.op  = decode_pkg::op_jalr;
      end
      `OPC_LUI: begin
        dec_o.cls = decode_pkg::cls_lui;
        dec_o.op  = decode_pkg::op_lui;
      end
      `OPC_AUIPC: begin
        dec_o.cls = decode_pkg::cls_auipc;
        dec_o.op  = decode_pkg::op_auipc;
      end
      `OPC_OP: begin
        dec_o.cls = decode_pkg::cls_reg_reg;
        // funct7[0] selects the M extension
        if (funct7[0]) begin
          case (funct3)
            3'b000: dec_o.op = decode_pkg::op_mul;
            3'b001: dec_o.op = decode_pkg::op_mulh;
            3'b010: dec_o.op = decode_pkg::op_mulhsu;
            3'b011: dec_o.op = decode_pkg::op_mulhu;
            3'b100: dec_o.op = decode_pkg::op_div;
            3'b101: dec_o.op = decode_pkg::op_divu;
            3'b110: dec_o.op = decode_pkg::op_rem;
            3'b111: dec_o.op = decode_pkg::op_remu;
          endcase
        end else begin
          case (funct3)
            3'b000: dec_o.op = funct7[5] ? decode_pkg::op_sub : decode_pkg::op_add;
            3'b001: dec_o.op = decode_pkg::op_sll;
            3'b010: dec_o.op = decode_pkg::op_slt;
            3'b011: dec_o.op = decode_pkg::op_sltu;
            3'b100: dec_o.op = decode_pkg::op_xor;
            3'b101: dec_o.op = funct7[5] ? decode_pkg::op_sra : decode_pkg::op_srl;
            3'b110: dec_o.op = decode_pkg::op_or;
            3'b111: dec_o.op = decode_pkg::op_and;
          endcase
        end
      end
      `OPC_OP_IMM: begin
        dec_o.cls = decode_pkg::cls_reg_imm;
        case (funct3)
          3'b000: dec_o.op = decode_pkg::op_add;
          3'b001: dec_o.op = decode_pkg::op_sll;
          3'b010: dec_o.op = decode_pkg::op_slt;
          3'b011: dec_o.op = decode_pkg::op_sltu;
          3'b100: dec_o.op = decode_pkg::op_xor;
          3'b101: dec_o.op = inst_i[30] ? decode_pkg::op_sra : decode_pkg::op_srl;
          3'b110: dec_o.op = decode_pkg::op_or;
          3'b111: dec_o.op = decode_pkg::op_and;
        endcase
      end
      `OPC_OP_32: begin
        dec_o.cls = decode_pkg::cls_reg_reg_w;
        case ({funct7[0], funct3})
          4'b0000: dec_o.op = funct7[5] ? decode_pkg::op_subw : decode_pkg::op_addw;
          4'b0001: dec_o.op = decode_pkg::op_sllw;
          4'b0101: dec_o.op = funct7[5] ? decode_pkg::op_sraw : decode_pkg::op_srlw;
          4'b1000: dec_o.op = decode_pkg::op_mulw;
          4'b1100: dec_o.op = decode_pkg::op_divw;
          4'b1101: dec_o.op = decode_pkg::op_divuw;
          4'b1110: dec_o.op = decode_pkg::op_remw;
          4'b1111: dec_o.op = decode_pkg::op_remuw;
          default: dec_o.op = decode_pkg::op_none;
        endcase
      end
      `OPC_OP_IMM_32: begin
        dec_o.cls = decode_pkg::cls_reg_imm_w;
        case (funct3)
          3'b000:  dec_o.op = decode_pkg::op_addw;
          3'b001:  dec_o.op = decode_pkg::op_sllw;
          3'b101:  dec_o.op = inst_i[30] ? decode_pkg::op_sraw : decode_pkg::op_srlw;
          default: dec_o.op = decode_pkg::op_none;
        endcase
      end
      default: begin
        dec_o.cls = decode_pkg::cls_none;
        dec_o.op  = decode_pkg::op_none;
      end
    endcase

    // register usage follows the class
    dec_o.read1 = dec_o.cls inside {decode_pkg::cls_load, decode_pkg::cls_store,
                                    decode_pkg::cls_branch, decode_pkg::cls_reg_reg,
                                    decode_pkg::cls_reg_imm, decode_pkg::cls_reg_reg_w,
                                    decode_pkg::cls_reg_imm_w, decode_pkg::cls_jalr};
    dec_o.read2 = dec_o.cls inside {decode_pkg::cls_store, decode_pkg::cls_branch,
                                    decode_pkg::cls_reg_reg, decode_pkg::cls_reg_reg_w};
    dec_o.rd_ena = (dec_o.rd != '0) &&
                   !(dec_o.cls inside {decode_pkg::cls_none, decode_pkg::cls_store,
                                       decode_pkg::cls_branch});
  end

endmodule

`default_nettype wire

//--- hdl/operand_forward.sv
/* operand forwarding select */
`timescale 1ns/1ps
`default_nettype none

`include "decode_config.svh"

module operand_forward (
  input  logic                   read_i,
  input  logic [`REG_ADDR_W-1:0] addr_i,
  input  logic [`XLEN-1:0]       rf_data_i,
  input  decode_pkg::fwd_src_t   alu1_i,
  input  decode_pkg::fwd_src_t   alu2_i,
  input  decode_pkg::fwd_src_t   mem_i,
  output logic [`XLEN-1:0]       data_o,
  output logic                   fwd_o
);

  logic hit_alu1;
  logic hit_alu2;
  logic hit_mem;
  logic alu2_newer;

  assign hit_alu1 = alu1_i.rd_ena && (alu1_i.rd_addr == addr_i);
  assign hit_alu2 = alu2_i.rd_ena && (alu2_i.rd_addr == addr_i);
  assign hit_mem  = mem_i.rd_ena && (mem_i.rd_addr == addr_i);

  // younger instruction has the larger pc
  assign alu2_newer = alu2_i.pc > alu1_i.pc;

  always_comb begin
    data_o = '0;
    fwd_o  = 1'b0;
    if (read_i) begin
      fwd_o = 1'b1;
      if (hit_alu1 && hit_alu2) begin
        data_o = alu2_newer ? alu2_i.data : alu1_i.data;
      end else if (hit_alu1) begin
        data_o = alu1_i.data;
      end else if (hit_alu2) begin
        data_o = alu2_i.data;
      end else if (hit_mem) begin
        data_o = mem_i.data;
      end else begin
        // nothing in flight, regfile value
        data_o = rf_data_i;
        fwd_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/decode_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_resolve.sv
hdl/decode_stage.sv
bench/tb_clock.sv
bench/decode_stage_tb.sv
